// File: design/pipe_pkg.sv
package pipe_pkg;

    localparam int DATA_W = 32;
    localparam int REG_W  = 5;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_SLL  = 4'd6,
        ALU_SRL  = 4'd7,
        ALU_SRA  = 4'd8,
        ALU_SLT  = 4'd9,
        ALU_SLTU = 4'd10,
        ALU_LUI  = 4'd11,
        ALU_LINK = 4'd12
    } alu_op_t;

    // one-hot load kind, all zero when not a load
    typedef logic [4:0] load_op_t;
    localparam int LD_BU = 0;
    localparam int LD_HU = 1;
    localparam int LD_W  = 2;
    localparam int LD_B  = 3;
    localparam int LD_H  = 4;

    typedef logic [2:0] store_op_t;
    localparam int ST_B = 0;
    localparam int ST_H = 1;
    localparam int ST_W = 2;

    typedef logic [8:0] branch_op_t;
    localparam int BR_EQ  = 0;
    localparam int BR_NE  = 1;
    localparam int BR_LT  = 2;
    localparam int BR_GE  = 3;
    localparam int BR_LTU = 4;
    localparam int BR_GEU = 5;
    localparam int BR_J   = 6;
    localparam int BR_JAL = 7;
    localparam int BR_JR  = 8;

    typedef struct packed {
        logic [DATA_W-1:0] pc;
        alu_op_t           alu_op;
        logic [DATA_W-1:0] src1;
        logic [DATA_W-1:0] src2;
        logic [DATA_W-1:0] imm;
        logic [DATA_W-1:0] store_data;
        logic [REG_W-1:0]  dest;
        logic              reg_we;
        load_op_t          load_op;
        store_op_t         store_op;
        branch_op_t        branch_op;
    } id_to_es_t;

    typedef struct packed {
        logic [DATA_W-1:0] pc;
        logic [DATA_W-1:0] alu_result;
        logic [DATA_W-1:0] br_target;
        logic [REG_W-1:0]  dest;
        logic              reg_we;
        load_op_t          load_op;
        branch_op_t        branch_op;
        logic              carry;
        logic              sign;
        logic              overflow;
        logic              zero;
    } es_to_ms_t;

    typedef struct packed {
        logic [DATA_W-1:0] pc;
        logic [DATA_W-1:0] result;
        logic [REG_W-1:0]  dest;
        logic              reg_we;
        logic              br_taken;
        logic [DATA_W-1:0] br_target;
    } ms_to_ws_t;

    typedef ms_to_ws_t retire_t;

endpackage

// File: design/data_ram.sv
module data_ram #(
    parameter int RAM_ADDR_W = 8
) (
    input  logic                  clk,
    input  logic                  en,
    input  logic [3:0]            we,
    input  logic [RAM_ADDR_W-1:0] addr,
    input  logic [31:0]           wdata,
    output logic [31:0]           rdata
);

    localparam int DEPTH = 1 << RAM_ADDR_W;

    logic [31:0] mem [DEPTH];

    // byte-enabled write
    always_ff @(posedge clk) begin
        if (en) begin
            for (int b = 0; b < 4; b++) begin
                if (we[b]) begin
                    mem[addr][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

    // read word holds until the next request
    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= mem[addr];
        end
    end

endmodule

// File: design/ex_stage.sv
module ex_stage #(
    parameter int RAM_ADDR_W = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  id_valid,
    input  pipe_pkg::id_to_es_t   id_inst,
    output logic                  es_allowin,
    input  logic                  ms_allowin,
    output logic                  es_to_ms_valid,
    output pipe_pkg::es_to_ms_t   es_to_ms,
    output logic                  ram_en,
    output logic [3:0]            ram_we,
    output logic [RAM_ADDR_W-1:0] ram_addr,
    output logic [31:0]           ram_wdata
);
    import pipe_pkg::*;

    logic              es_valid;
    id_to_es_t         es_inst;
    logic              handoff;
    logic [DATA_W:0]   sub_full;
    logic [DATA_W-1:0] diff;
    logic              carry;
    logic              overflow;
    logic [DATA_W-1:0] alu_out;
    logic [DATA_W-1:0] mem_addr;
    logic              is_load;
    logic              is_store;
    logic [3:0]        lane_we;
    logic [DATA_W-1:0] lane_data;

    assign es_allowin     = !es_valid || ms_allowin;
    assign es_to_ms_valid = es_valid;
    assign handoff        = es_valid && ms_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= id_valid;
        end
        if (id_valid && es_allowin) begin
            es_inst <= id_inst;
        end
    end

    // src1 - src2 with the borrow in the top bit
    assign sub_full = {1'b0, es_inst.src1} - {1'b0, es_inst.src2};
    assign diff     = sub_full[DATA_W-1:0];
    assign carry    = sub_full[DATA_W];
    assign overflow = (es_inst.src1[DATA_W-1] != es_inst.src2[DATA_W-1])
                   && (diff[DATA_W-1] != es_inst.src1[DATA_W-1]);

    always_comb begin
        case (es_inst.alu_op)
            ALU_ADD:  alu_out = es_inst.src1 + es_inst.src2;
            ALU_SUB:  alu_out = diff;
            ALU_AND:  alu_out = es_inst.src1 & es_inst.src2;
            ALU_OR:   alu_out = es_inst.src1 | es_inst.src2;
            ALU_XOR:  alu_out = es_inst.src1 ^ es_inst.src2;
            ALU_NOR:  alu_out = ~(es_inst.src1 | es_inst.src2);
            ALU_SLL:  alu_out = es_inst.src1 << es_inst.src2[4:0];
            ALU_SRL:  alu_out = es_inst.src1 >> es_inst.src2[4:0];
            ALU_SRA:  alu_out = $signed(es_inst.src1) >>> es_inst.src2[4:0];
            ALU_SLT:  alu_out = {{(DATA_W-1){1'b0}}, diff[DATA_W-1] != overflow};
            ALU_SLTU: alu_out = {{(DATA_W-1){1'b0}}, carry};
            ALU_LUI:  alu_out = {es_inst.imm[15:0], 16'h0000};
            ALU_LINK: alu_out = es_inst.pc + 32'd8;
            default:  alu_out = '0;
        endcase
    end

    assign mem_addr = es_inst.src1 + es_inst.imm;
    assign is_load  = |es_inst.load_op;
    assign is_store = |es_inst.store_op;

    // move store data into the lane picked by the low address bits
    always_comb begin
        lane_we   = 4'b0000;
        lane_data = es_inst.store_data;
        if (es_inst.store_op[ST_B]) begin
            lane_we   = 4'b0001 << mem_addr[1:0];
            lane_data = {24'h0, es_inst.store_data[7:0]} << {mem_addr[1:0], 3'b000};
        end else if (es_inst.store_op[ST_H]) begin
            lane_we   = mem_addr[1] ? 4'b1100 : 4'b0011;
            lane_data = {16'h0, es_inst.store_data[15:0]} << {mem_addr[1], 4'b0000};
        end else if (es_inst.store_op[ST_W]) begin
            lane_we   = 4'b1111;
        end
    end

    // request only on the handoff edge so the read lines up with mem_stage
    assign ram_en    = handoff && (is_load || is_store);
    assign ram_we    = ram_en ? lane_we : 4'b0000;
    assign ram_addr  = mem_addr[RAM_ADDR_W+1:2];
    assign ram_wdata = lane_data;

    always_comb begin
        es_to_ms.pc         = es_inst.pc;
        es_to_ms.alu_result = (is_load || is_store) ? mem_addr : alu_out;
        es_to_ms.br_target  = es_inst.branch_op[BR_JR] ? es_inst.src1
                                                       : es_inst.pc + es_inst.imm;
        es_to_ms.dest       = es_inst.dest;
        es_to_ms.reg_we     = es_inst.reg_we;
        es_to_ms.load_op    = es_inst.load_op;
        es_to_ms.branch_op  = es_inst.branch_op;
        es_to_ms.carry      = carry;
        es_to_ms.sign       = diff[DATA_W-1];
        es_to_ms.overflow   = overflow;
        es_to_ms.zero       = (diff == '0);
    end

endmodule

// File: design/mem_stage.sv
module mem_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                es_to_ms_valid,
    input  pipe_pkg::es_to_ms_t es_to_ms,
    output logic                ms_allowin,
    input  logic                ws_allowin,
    output logic                ms_to_ws_valid,
    output pipe_pkg::ms_to_ws_t ms_to_ws,
    input  logic [31:0]         ram_rdata
);
    import pipe_pkg::*;

    logic              ms_valid;
    es_to_ms_t         ms_rec;
    logic [7:0]        ld_byte;
    logic [15:0]       ld_half;
    logic [DATA_W-1:0] load_data;
    logic              br_taken;

    assign ms_allowin     = !ms_valid || ws_allowin;
    assign ms_to_ws_valid = ms_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es_to_ms_valid;
        end
        if (es_to_ms_valid && ms_allowin) begin
            ms_rec <= es_to_ms;
        end
    end

    // pick the addressed byte and half out of the read word
    always_comb begin
        case (ms_rec.alu_result[1:0])
            2'b00:   ld_byte = ram_rdata[7:0];
            2'b01:   ld_byte = ram_rdata[15:8];
            2'b10:   ld_byte = ram_rdata[23:16];
            default: ld_byte = ram_rdata[31:24];
        endcase
        ld_half = ms_rec.alu_result[1] ? ram_rdata[31:16] : ram_rdata[15:0];
    end

    always_comb begin
        load_data = '0;
        if (ms_rec.load_op[LD_BU]) begin
            load_data = {24'h0, ld_byte};
        end else if (ms_rec.load_op[LD_B]) begin
            load_data = {{24{ld_byte[7]}}, ld_byte};
        end else if (ms_rec.load_op[LD_HU]) begin
            load_data = {16'h0, ld_half};
        end else if (ms_rec.load_op[LD_H]) begin
            load_data = {{16{ld_half[15]}}, ld_half};
        end else if (ms_rec.load_op[LD_W]) begin
            load_data = ram_rdata;
        end
    end

    // conditions from the execute flags, jumps always go
    assign br_taken = ms_rec.branch_op[BR_EQ]  &&  ms_rec.zero
                   || ms_rec.branch_op[BR_NE]  && !ms_rec.zero
                   || ms_rec.branch_op[BR_LT]  && (ms_rec.sign != ms_rec.overflow)
                   || ms_rec.branch_op[BR_GE]  && (ms_rec.sign == ms_rec.overflow)
                   || ms_rec.branch_op[BR_LTU] &&  ms_rec.carry
                   || ms_rec.branch_op[BR_GEU] && !ms_rec.carry
                   || ms_rec.branch_op[BR_J]
                   || ms_rec.branch_op[BR_JAL]
                   || ms_rec.branch_op[BR_JR];

    always_comb begin
        ms_to_ws.pc        = ms_rec.pc;
        ms_to_ws.result    = (|ms_rec.load_op) ? load_data : ms_rec.alu_result;
        ms_to_ws.dest      = ms_rec.dest;
        ms_to_ws.reg_we    = ms_rec.reg_we;
        ms_to_ws.br_taken  = br_taken;
        ms_to_ws.br_target = ms_rec.br_target;
    end

endmodule

// File: design/wb_stage.sv
module wb_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                ms_to_ws_valid,
    input  pipe_pkg::ms_to_ws_t ms_to_ws,
    output logic                ws_allowin,
    output logic                retire_valid,
    output pipe_pkg::retire_t   retire,
    input  logic                retire_ready
);
    import pipe_pkg::*;

    logic      ws_valid;
    ms_to_ws_t ws_rec;
    logic      ret_allowin;

    // retire port is registered, so it moves on when empty or taken
    assign ret_allowin = !retire_valid || retire_ready;
    assign ws_allowin  = !ws_valid || ret_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= ms_to_ws_valid;
        end
        if (ms_to_ws_valid && ws_allowin) begin
            ws_rec <= ms_to_ws;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            retire_valid <= 1'b0;
        end else if (ret_allowin) begin
            retire_valid <= ws_valid;
        end
        if (ws_valid && ret_allowin) begin
            retire <= ws_rec;
        end
    end

endmodule

// File: design/pipe_backend.sv
module pipe_backend #(
    parameter int RAM_ADDR_W = 8
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                id_valid,
    input  pipe_pkg::id_to_es_t id_inst,
    output logic                es_allowin,
    output logic                retire_valid,
    output pipe_pkg::retire_t   retire,
    input  logic                retire_ready
);
    import pipe_pkg::*;

    logic                  ms_allowin;
    logic                  ws_allowin;
    logic                  es_to_ms_valid;
    es_to_ms_t             es_to_ms;
    logic                  ms_to_ws_valid;
    ms_to_ws_t             ms_to_ws;
    logic                  ram_en;
    logic [3:0]            ram_we;
    logic [RAM_ADDR_W-1:0] ram_addr;
    logic [31:0]           ram_wdata;
    logic [31:0]           ram_rdata;

    ex_stage #(
        .RAM_ADDR_W(RAM_ADDR_W)
    ) i_ex_stage (
        .clk           (clk),
        .reset         (reset),
        .id_valid      (id_valid),
        .id_inst       (id_inst),
        .es_allowin    (es_allowin),
        .ms_allowin    (ms_allowin),
        .es_to_ms_valid(es_to_ms_valid),
        .es_to_ms      (es_to_ms),
        .ram_en        (ram_en),
        .ram_we        (ram_we),
        .ram_addr      (ram_addr),
        .ram_wdata     (ram_wdata)
    );

    mem_stage i_mem_stage (
        .clk           (clk),
        .reset         (reset),
        .es_to_ms_valid(es_to_ms_valid),
        .es_to_ms      (es_to_ms),
        .ms_allowin    (ms_allowin),
        .ws_allowin    (ws_allowin),
        .ms_to_ws_valid(ms_to_ws_valid),
        .ms_to_ws      (ms_to_ws),
        .ram_rdata     (ram_rdata)
    );

    wb_stage i_wb_stage (
        .clk           (clk),
        .reset         (reset),
        .ms_to_ws_valid(ms_to_ws_valid),
        .ms_to_ws      (ms_to_ws),
        .ws_allowin    (ws_allowin),
        .retire_valid  (retire_valid),
        .retire        (retire),
        .retire_ready  (retire_ready)
    );

    data_ram #(
        .RAM_ADDR_W(RAM_ADDR_W)
    ) i_data_ram (
        .clk  (clk),
        .en   (ram_en),
        .we   (ram_we),
        .addr (ram_addr),
        .wdata(ram_wdata),
        .rdata(ram_rdata)
    );

endmodule

// File: sim/tb_pipe_backend.sv
module tb_pipe_backend;
    timeunit 1ns;
    timeprecision 1ps;
    import pipe_pkg::*;

    localparam int WAIT_LIMIT = 2000;

    logic      clk;
    logic      reset;
    logic      id_valid;
    id_to_es_t id_inst;
    logic      es_allowin;
    logic      retire_valid;
    retire_t   retire;
    logic      retire_ready;

    id_to_es_t rows[$];
    retire_t   expect_rec[$];
    int        grp_of[$];
    int        gaps[$];
    int        pending[$];
    integer    seed;
    logic      stall_en;
    logic      aborted = 1'b0;
    int        errors;
    int        retired;

    pipe_backend #(
        .RAM_ADDR_W(8)
    ) i_dut (
        .clk         (clk),
        .reset       (reset),
        .id_valid    (id_valid),
        .id_inst     (id_inst),
        .es_allowin  (es_allowin),
        .retire_valid(retire_valid),
        .retire      (retire),
        .retire_ready(retire_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ends the run as soon as any wait gives up
    initial begin
        wait (aborted);
        $display("Errors found");
        $finish;
    end

    // retire port stalls, random only while enabled
    initial begin
        forever begin
            @(posedge clk);
            #1;
            if (stall_en) begin
                retire_ready = 1'($random(seed) & 1);
            end else begin
                retire_ready = 1'b1;
            end
        end
    end

    task automatic load_vectors();
        int          fd;
        int          got;
        string       line;
        logic [31:0] f [17];
        id_to_es_t   inst;
        retire_t     rec;
        fd = $fopen("sim/backend_input.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/backend_input.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line[0] == "#") begin
                    continue;
                end
                got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                              f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                              f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
                if (got != 17) begin
                    $display("vector line has the wrong number of columns: %s", line);
                    errors++;
                    continue;
                end
                inst.pc         = f[1];
                inst.alu_op     = alu_op_t'(f[2][3:0]);
                inst.src1       = f[3];
                inst.src2       = f[4];
                inst.imm        = f[5];
                inst.store_data = f[6];
                inst.dest       = f[7][4:0];
                inst.reg_we     = f[8][0];
                inst.load_op    = f[9][4:0];
                inst.store_op   = f[10][2:0];
                inst.branch_op  = f[11][8:0];
                // pc passes through unchanged
                rec.pc        = f[1];
                rec.result    = f[12];
                rec.dest      = f[13][4:0];
                rec.reg_we    = f[14][0];
                rec.br_taken  = f[15][0];
                rec.br_target = f[16];
                rows.push_back(inst);
                expect_rec.push_back(rec);
                grp_of.push_back(int'(f[0]));
                gaps.push_back($random(seed) & 3);
            end
            $fclose(fd);
        end
    endtask

    task automatic compare_field(input string name, input int row,
                                 input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("FAILED row %0d %s: got %h expected %h", row, name, got, want);
            errors++;
        end
    endtask

    task automatic check_retire();
        int idx;
        if (pending.size() == 0) begin
            $display("an instruction retired with nothing outstanding, pc %h", retire.pc);
            errors++;
        end else begin
            idx = pending.pop_front();
            compare_field("retire.pc", idx, retire.pc, expect_rec[idx].pc);
            compare_field("retire.result", idx, retire.result, expect_rec[idx].result);
            compare_field("retire.dest", idx, 32'(retire.dest), 32'(expect_rec[idx].dest));
            compare_field("retire.reg_we", idx, 32'(retire.reg_we),
                          32'(expect_rec[idx].reg_we));
            compare_field("retire.br_taken", idx, 32'(retire.br_taken),
                          32'(expect_rec[idx].br_taken));
            compare_field("retire.br_target", idx, retire.br_target,
                          expect_rec[idx].br_target);
            retired++;
        end
    endtask

    // a transfer happens on the next rising edge
    always @(negedge clk) begin
        if (!reset && retire_valid && retire_ready) begin
            check_retire();
        end
    end

    // hold one row on the input until es_allowin takes it
    task automatic issue_row(input int idx);
        int waited;
        waited   = 0;
        id_inst  = rows[idx];
        id_valid = 1'b1;
        @(negedge clk);
        while (!es_allowin) begin
            if (waited == WAIT_LIMIT) begin
                $display("timeout: row %0d was never accepted", idx);
                errors++;
                aborted = 1'b1;
            end
            waited++;
            @(negedge clk);
        end
        pending.push_back(idx);
        @(posedge clk);
        #1;
        id_valid = 1'b0;
    endtask

    task automatic drain_pending(input string name);
        int waited;
        waited = 0;
        while (pending.size() != 0) begin
            if (waited == WAIT_LIMIT) begin
                $display("timeout: %s left instructions that never retired", name);
                errors++;
                aborted = 1'b1;
            end
            waited++;
            @(posedge clk);
            #1;
        end
        // idle a while so a duplicate retire would show up
        repeat (8) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_group(input int num, input int grp, input string name);
        int e0;
        int r0;
        int issued;
        e0     = errors;
        r0     = retired;
        issued = 0;
        for (int i = 0; i < rows.size(); i++) begin
            if (grp == 0 || grp_of[i] == grp) begin
                repeat (gaps[i]) begin
                    @(posedge clk);
                    #1;
                end
                issue_row(i);
                issued++;
            end
        end
        drain_pending(name);
        if (retired - r0 != issued) begin
            $display("%s issued %0d instructions but %0d retired", name, issued, retired - r0);
            errors++;
        end
        $display("test %0d %s: %0d retired, %0d errors", num, name, retired - r0, errors - e0);
    endtask

    initial begin
        int e0;
        int edges;
        seed         = 32'h3f3d_4a1e;
        errors       = 0;
        retired      = 0;
        stall_en     = 1'b0;
        reset        = 1'b1;
        id_valid     = 1'b0;
        id_inst      = '0;
        retire_ready = 1'b1;
        load_vectors();
        if (rows.size() == 0) begin
            $display("no vectors were read");
            errors++;
            aborted = 1'b1;
        end

        repeat (16) begin
            @(posedge clk);
            #1;
        end
        reset = 1'b0;
        e0    = errors;
        @(negedge clk);
        if (retire_valid !== 1'b0) begin
            $display("retire_valid is not low after reset");
            errors++;
        end
        if (es_allowin !== 1'b1) begin
            $display("es_allowin is not high after reset");
            errors++;
        end
        $display("test 1 after reset: %0d errors", errors - e0);
        @(posedge clk);
        #1;

        run_group(2, 2, "alu ops");
        run_group(3, 3, "stores and loads");
        run_group(4, 4, "branches");

        stall_en = 1'b1;
        run_group(5, 0, "back-pressure");
        stall_en = 1'b0;

        // one isolated instruction with the retire port open
        e0 = errors;
        repeat (2) begin
            @(posedge clk);
            #1;
        end
        issue_row(0);
        edges = 0;
        @(negedge clk);
        while (!retire_valid) begin
            if (edges == WAIT_LIMIT) begin
                $display("timeout: the isolated instruction never retired");
                errors++;
                aborted = 1'b1;
            end
            @(posedge clk);
            edges++;
            @(negedge clk);
        end
        if (edges != 3) begin
            $display("FAILED issue-to-retire edges: got %h expected %h", edges, 3);
            errors++;
        end
        drain_pending("latency");
        $display("test 6 latency: %0d edges, %0d errors", edges, errors - e0);

        $display("total: %0d retired, %0d errors", retired, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: sim/backend_input.txt
# grp pc alu_op src1 src2 imm store_data dest reg_we load_op store_op branch_op
# then expected result dest reg_we br_taken br_target, all columns in hex
2 100 0 7fffffff 1 0 0 1 1 0 0 0 80000000 1 1 0 100
2 104 1 5 7 0 0 2 1 0 0 0 fffffffe 2 1 0 104
2 108 2 f0f0ff00 0ff0f0f0 0 0 3 1 0 0 0 00f0f000 3 1 0 108
2 10c 3 f0f0ff00 0ff0f0f0 0 0 4 1 0 0 0 fff0fff0 4 1 0 10c
2 110 4 f0f0ff00 0ff0f0f0 0 0 5 1 0 0 0 ff000ff0 5 1 0 110
2 114 5 f0f0ff00 0ff0f0f0 0 0 6 1 0 0 0 000f000f 6 1 0 114
2 118 6 81 24 0 0 7 1 0 0 0 810 7 1 0 118
2 11c 7 80000000 1f 0 0 8 1 0 0 0 1 8 1 0 11c
2 120 8 80000000 4 0 0 9 1 0 0 0 f8000000 9 1 0 120
2 124 9 80000000 1 0 0 a 1 0 0 0 1 a 1 0 124
2 128 a 80000000 1 0 0 0 0 0 0 0 0 0 0 0 128
2 12c b 0 0 1234 0 b 1 0 0 0 12340000 b 1 0 1360
2 130 c 0 0 0 0 1f 1 0 0 0 138 1f 1 0 130
3 200 0 40 0 0 80ff7f01 0 0 0 4 0 40 0 0 0 200
3 204 0 40 0 4 12345681 0 0 0 1 0 44 0 0 0 208
3 208 0 40 0 5 1234567f 0 0 0 1 0 45 0 0 0 20d
3 20c 0 40 0 6 12345600 0 0 0 1 0 46 0 0 0 212
3 210 0 40 0 7 123456fe 0 0 0 1 0 47 0 0 0 217
3 214 0 40 0 8 abcd8001 0 0 0 2 0 48 0 0 0 21c
3 218 0 40 0 a abcd7ffe 0 0 0 2 0 4a 0 0 0 222
3 21c 0 40 0 4 0 11 1 8 0 0 ffffff81 11 1 0 220
3 220 0 40 0 7 0 12 1 8 0 0 fffffffe 12 1 0 227
3 224 0 40 0 5 0 13 1 1 0 0 7f 13 1 0 229
3 228 0 40 0 8 0 14 1 10 0 0 ffff8001 14 1 0 230
3 22c 0 40 0 a 0 15 1 10 0 0 7ffe 15 1 0 236
3 230 0 40 0 8 0 16 1 2 0 0 8001 16 1 0 238
3 234 0 40 0 a 0 17 1 2 0 0 7ffe 17 1 0 23e
3 238 0 40 0 0 0 18 1 4 0 0 80ff7f01 18 1 0 238
3 23c 0 40 0 4 0 19 1 4 0 0 fe007f81 19 1 0 240
4 300 0 5 5 40 0 0 0 0 0 1 a 0 0 1 340
4 304 0 5 6 40 0 0 0 0 0 1 b 0 0 0 344
4 308 0 5 6 40 0 0 0 0 0 2 b 0 0 1 348
4 30c 0 80000000 7fffffff 40 0 0 0 0 0 4 ffffffff 0 0 1 34c
4 310 0 7fffffff 80000000 40 0 0 0 0 0 4 ffffffff 0 0 0 350
4 314 0 ffffffff ffffffff 40 0 0 0 0 0 8 fffffffe 0 0 1 354
4 318 0 ffffffff 0 40 0 0 0 0 0 8 ffffffff 0 0 0 358
4 31c 0 0 ffffffff 40 0 0 0 0 0 10 ffffffff 0 0 1 35c
4 320 0 ffffffff 0 40 0 0 0 0 0 10 ffffffff 0 0 0 360
4 324 0 80000000 7fffffff 40 0 0 0 0 0 20 ffffffff 0 0 1 364
4 328 0 7fffffff 80000000 40 0 0 0 0 0 20 ffffffff 0 0 0 368
4 32c 0 0 0 fffffff0 0 0 0 0 0 40 0 0 0 1 31c
4 330 c 0 0 100 0 1f 1 0 0 80 338 1f 1 1 430
4 334 0 1000 0 40 0 0 0 0 0 100 1000 0 0 1 1000

// File: pipe_backend.f
design/pipe_pkg.sv
design/data_ram.sv
design/ex_stage.sv
design/mem_stage.sv
design/wb_stage.sv
design/pipe_backend.sv
sim/tb_pipe_backend.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_pipe_backend
FILELIST  = pipe_backend.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = No errors

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell grep -v '^+' $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
